// ==== pipe_pkg.sv ====
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  br_kind_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_SLL  = 4'd7;
    localparam alu_op_t ALU_SRL  = 4'd8;
    localparam alu_op_t ALU_SRA  = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10; // passes src2

    // branch kinds
    localparam br_kind_t BR_NONE = 3'd0;
    localparam br_kind_t BR_BEQ  = 3'd1;
    localparam br_kind_t BR_BNE  = 3'd2;
    localparam br_kind_t BR_BLT  = 3'd3;
    localparam br_kind_t BR_BGE  = 3'd4;
    localparam br_kind_t BR_B    = 3'd5;
    localparam br_kind_t BR_JIRL = 3'd6; // target from rj

    // memory access progress in the execute stage
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } exm_state_t;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
    input  pipe_pkg::alu_op_t alu_op,
    input  pipe_pkg::word_t   src1,
    input  pipe_pkg::word_t   src2,
    output pipe_pkg::word_t   alu_result,
    output logic              zero,
    output logic              less,
    input  logic              is_unsigned
);

    logic       slt;
    logic       sltu;
    logic [4:0] shamt;

    assign slt   = $signed(src1) < $signed(src2);
    assign sltu  = src1 < src2;
    assign shamt = src2[4:0]; // low 5 bits only

    always_comb begin
        case (alu_op)
            pipe_pkg::ALU_ADD: begin
                alu_result = src1 + src2;
            end
            pipe_pkg::ALU_SUB: begin
                alu_result = src1 - src2;
            end
            pipe_pkg::ALU_SLT: begin
                alu_result = {31'b0, slt};
            end
            pipe_pkg::ALU_SLTU: begin
                alu_result = {31'b0, sltu};
            end
            pipe_pkg::ALU_AND: begin
                alu_result = src1 & src2;
            end
            pipe_pkg::ALU_OR: begin
                alu_result = src1 | src2;
            end
            pipe_pkg::ALU_XOR: begin
                alu_result = src1 ^ src2;
            end
            pipe_pkg::ALU_SLL: begin
                alu_result = src1 << shamt;
            end
            pipe_pkg::ALU_SRL: begin
                alu_result = src1 >> shamt;
            end
            pipe_pkg::ALU_SRA: begin
                alu_result = $signed(src1) >>> shamt;
            end
            pipe_pkg::ALU_LUI: begin
                alu_result = src2;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    // flags feed the branch unit
    assign zero = src1 == src2;
    assign less = is_unsigned ? sltu : slt;

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit (
    input  logic               first_cycle,
    input  pipe_pkg::br_kind_t br_kind,
    input  logic               zero,
    input  logic               less,
    input  pipe_pkg::word_t    pc,
    input  pipe_pkg::word_t    rj_value,
    input  pipe_pkg::word_t    imm,
    output logic               br_taken,
    output pipe_pkg::word_t    br_target,
    output logic               flush_if,
    output logic               flush_id
);

    logic            cond;
    pipe_pkg::word_t target;

    always_comb begin
        case (br_kind)
            pipe_pkg::BR_BEQ:  cond = zero;
            pipe_pkg::BR_BNE:  cond = !zero;
            pipe_pkg::BR_BLT:  cond = less;
            pipe_pkg::BR_BGE:  cond = !less;
            pipe_pkg::BR_B:    cond = 1'b1;
            pipe_pkg::BR_JIRL: cond = 1'b1;
            default:           cond = 1'b0;
        endcase
    end

    assign target = (br_kind == pipe_pkg::BR_JIRL) ? rj_value + imm : pc + imm;

    // only the first cycle in the stage reports the branch
    assign br_taken  = first_cycle && cond;
    assign br_target = br_taken ? target : '0;

    // fetch and decode always follow the fall-through path
    assign flush_if = br_taken;
    assign flush_id = br_taken;

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
    parameter int ram_words = 256
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            wb_cyc,
    input  logic            wb_stb,
    input  logic            wb_we,
    input  pipe_pkg::word_t wb_adr,
    input  pipe_pkg::word_t wb_dat_w,
    input  logic [3:0]      wb_sel,
    output logic            wb_ack,
    output pipe_pkg::word_t wb_dat_r
);

    localparam int idx_w = $clog2(ram_words);

    pipe_pkg::word_t   mem [ram_words];
    logic [idx_w-1:0]  idx;
    logic              req;

    assign idx = wb_adr[idx_w+1:2]; // power of two depth wraps here
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req; // one cycle, never back to back
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= mem[idx];
            if (wb_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel[b]) mem[idx][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== exm_stage.sv ====
`timescale 1ns/1ns

module exm_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ds_valid,
    output logic                es_allowin,
    input  pipe_pkg::word_t     pc,
    input  pipe_pkg::alu_op_t   alu_op,
    input  pipe_pkg::br_kind_t  br_kind,
    input  logic                is_unsigned,
    input  pipe_pkg::reg_addr_t rj,
    input  pipe_pkg::reg_addr_t rk,
    input  pipe_pkg::word_t     rj_value,
    input  pipe_pkg::word_t     rk_value,
    input  pipe_pkg::word_t     imm,
    input  logic                src1_is_pc,
    input  logic                src2_is_imm,
    input  logic                src2_is_4,
    input  logic                rd_we_in,
    input  pipe_pkg::reg_addr_t rd_in,
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  logic                fwd1_valid,
    input  pipe_pkg::reg_addr_t fwd1_rd,
    input  pipe_pkg::word_t     fwd1_value,
    input  logic                fwd2_valid,
    input  pipe_pkg::reg_addr_t fwd2_rd,
    input  pipe_pkg::word_t     fwd2_value,
    input  logic                ws_allowin,
    output logic                es_valid_out,
    output logic                rd_we,
    output pipe_pkg::reg_addr_t rd,
    output pipe_pkg::word_t     result,
    output pipe_pkg::word_t     pc_out,
    output logic                fwd_out_valid,
    output pipe_pkg::reg_addr_t fwd_out_rd,
    output pipe_pkg::word_t     fwd_out_value,
    output logic                br_taken,
    output pipe_pkg::word_t     br_target,
    output logic                flush_if,
    output logic                flush_id,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output pipe_pkg::word_t     wb_adr,
    output pipe_pkg::word_t     wb_dat_w,
    output logic [3:0]          wb_sel,
    input  logic                wb_ack,
    input  pipe_pkg::word_t     wb_dat_r
);

    logic                 es_valid;
    logic                 es_ready_go;
    logic                 accept;
    logic                 leave;
    logic                 first_cycle;
    logic                 is_mem;
    pipe_pkg::exm_state_t state;

    pipe_pkg::word_t     rj_fwd, rk_fwd;
    pipe_pkg::word_t     pc_r, rj_r, rk_r, imm_r, load_data;
    pipe_pkg::alu_op_t   alu_op_r;
    pipe_pkg::br_kind_t  br_kind_r;
    pipe_pkg::reg_addr_t rd_r;
    logic                is_unsigned_r, src1_is_pc_r, src2_is_imm_r, src2_is_4_r;
    logic                rd_we_r, mem_rd_r, mem_wr_r;

    pipe_pkg::word_t src1, src2, alu_result;
    logic            zero, less;

    // port 1 wins, r0 never forwarded
    assign rj_fwd = (rj != '0 && fwd1_valid && fwd1_rd == rj) ? fwd1_value :
                    (rj != '0 && fwd2_valid && fwd2_rd == rj) ? fwd2_value : rj_value;
    assign rk_fwd = (rk != '0 && fwd1_valid && fwd1_rd == rk) ? fwd1_value :
                    (rk != '0 && fwd2_valid && fwd2_rd == rk) ? fwd2_value : rk_value;

    assign is_mem       = mem_rd_r || mem_wr_r;
    assign es_ready_go  = !is_mem || state == pipe_pkg::ST_DONE;
    assign es_allowin   = !es_valid || (es_ready_go && ws_allowin);
    assign es_valid_out = es_valid && es_ready_go;
    assign accept       = ds_valid && es_allowin;
    assign leave        = es_valid_out && ws_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid    <= 1'b0;
            first_cycle <= 1'b0;
        end else begin
            if (es_allowin) begin
                es_valid <= ds_valid;
            end
            first_cycle <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_r          <= pc;
            alu_op_r      <= alu_op;
            br_kind_r     <= br_kind;
            is_unsigned_r <= is_unsigned;
            rj_r          <= rj_fwd;
            rk_r          <= rk_fwd;
            imm_r         <= imm;
            src1_is_pc_r  <= src1_is_pc;
            src2_is_imm_r <= src2_is_imm;
            src2_is_4_r   <= src2_is_4;
            rd_we_r       <= rd_we_in && !mem_wr; // stores never write back
            rd_r          <= rd_in;
            mem_rd_r      <= mem_rd;
            mem_wr_r      <= mem_wr;
        end
        if (state == pipe_pkg::ST_BUS && wb_ack) begin
            load_data <= wb_dat_r;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pipe_pkg::ST_IDLE;
        end else begin
            case (state)
                pipe_pkg::ST_IDLE: begin
                    if (accept && (mem_rd || mem_wr)) state <= pipe_pkg::ST_BUS;
                end
                pipe_pkg::ST_BUS: begin
                    if (wb_ack) state <= pipe_pkg::ST_DONE;
                end
                pipe_pkg::ST_DONE: begin
                    if (leave) begin
                        state <= (accept && (mem_rd || mem_wr)) ? pipe_pkg::ST_BUS
                                                                : pipe_pkg::ST_IDLE;
                    end
                end
                default: state <= pipe_pkg::ST_IDLE;
            endcase
        end
    end

    assign src1 = src1_is_pc_r ? pc_r : rj_r;
    assign src2 = src2_is_imm_r ? imm_r : src2_is_4_r ? 32'd4 : rk_r;

    alu u_alu (
        .alu_op      (alu_op_r),
        .src1        (src1),
        .src2        (src2),
        .alu_result  (alu_result),
        .zero        (zero),
        .less        (less),
        .is_unsigned (is_unsigned_r)
    );

    branch_unit u_branch (
        .first_cycle (first_cycle && es_valid),
        .br_kind     (br_kind_r),
        .zero        (zero),
        .less        (less),
        .pc          (pc_r),
        .rj_value    (rj_r),
        .imm         (imm_r),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .flush_if    (flush_if),
        .flush_id    (flush_id)
    );

    assign wb_cyc   = state == pipe_pkg::ST_BUS;
    assign wb_stb   = state == pipe_pkg::ST_BUS;
    assign wb_we    = mem_wr_r;
    assign wb_adr   = rj_r + imm_r;
    assign wb_dat_w = rk_r;
    assign wb_sel   = 4'hf; // word accesses only

    assign rd_we  = rd_we_r;
    assign rd     = rd_r;
    assign result = mem_rd_r ? load_data : alu_result;
    assign pc_out = pc_r;

    // a load forwards only once its data is back
    assign fwd_out_valid = es_valid && es_ready_go && rd_we_r;
    assign fwd_out_rd    = rd_r;
    assign fwd_out_value = result;

endmodule

// ==== exm_top.sv ====
`timescale 1ns/1ns

module exm_top #(
    parameter int ram_words = 256
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                ds_valid,
    output logic                es_allowin,
    input  pipe_pkg::word_t     pc,
    input  pipe_pkg::alu_op_t   alu_op,
    input  pipe_pkg::br_kind_t  br_kind,
    input  logic                is_unsigned,
    input  pipe_pkg::reg_addr_t rj,
    input  pipe_pkg::reg_addr_t rk,
    input  pipe_pkg::word_t     rj_value,
    input  pipe_pkg::word_t     rk_value,
    input  pipe_pkg::word_t     imm,
    input  logic                src1_is_pc,
    input  logic                src2_is_imm,
    input  logic                src2_is_4,
    input  logic                rd_we_in,
    input  pipe_pkg::reg_addr_t rd_in,
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  logic                fwd1_valid,
    input  pipe_pkg::reg_addr_t fwd1_rd,
    input  pipe_pkg::word_t     fwd1_value,
    input  logic                fwd2_valid,
    input  pipe_pkg::reg_addr_t fwd2_rd,
    input  pipe_pkg::word_t     fwd2_value,
    input  logic                ws_allowin,
    output logic                es_valid_out,
    output logic                rd_we,
    output pipe_pkg::reg_addr_t rd,
    output pipe_pkg::word_t     result,
    output pipe_pkg::word_t     pc_out,
    output logic                fwd_out_valid,
    output pipe_pkg::reg_addr_t fwd_out_rd,
    output pipe_pkg::word_t     fwd_out_value,
    output logic                br_taken,
    output pipe_pkg::word_t     br_target,
    output logic                flush_if,
    output logic                flush_id
);

    logic            wb_cyc, wb_stb, wb_we, wb_ack;
    pipe_pkg::word_t wb_adr, wb_dat_w, wb_dat_r;
    logic [3:0]      wb_sel;

    exm_stage u_exm (
        .clk (clk), .reset (reset),
        .ds_valid (ds_valid), .es_allowin (es_allowin),
        .pc (pc), .alu_op (alu_op), .br_kind (br_kind), .is_unsigned (is_unsigned),
        .rj (rj), .rk (rk), .rj_value (rj_value), .rk_value (rk_value), .imm (imm),
        .src1_is_pc (src1_is_pc), .src2_is_imm (src2_is_imm), .src2_is_4 (src2_is_4),
        .rd_we_in (rd_we_in), .rd_in (rd_in), .mem_rd (mem_rd), .mem_wr (mem_wr),
        .fwd1_valid (fwd1_valid), .fwd1_rd (fwd1_rd), .fwd1_value (fwd1_value),
        .fwd2_valid (fwd2_valid), .fwd2_rd (fwd2_rd), .fwd2_value (fwd2_value),
        .ws_allowin (ws_allowin), .es_valid_out (es_valid_out),
        .rd_we (rd_we), .rd (rd), .result (result), .pc_out (pc_out),
        .fwd_out_valid (fwd_out_valid), .fwd_out_rd (fwd_out_rd),
        .fwd_out_value (fwd_out_value),
        .br_taken (br_taken), .br_target (br_target),
        .flush_if (flush_if), .flush_id (flush_id),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_ack (wb_ack), .wb_dat_r (wb_dat_r)
    );

    data_ram #(
        .ram_words (ram_words)
    ) u_ram (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

endmodule

// ==== exm_sva.sv ====
`timescale 1ns/1ns

module exm_sva (
    input logic                clk,
    input logic                reset,
    input logic                ds_valid,
    input logic                es_allowin,
    input logic                es_valid_out,
    input logic                ws_allowin,
    input logic                rd_we,
    input pipe_pkg::reg_addr_t rd,
    input pipe_pkg::word_t     result,
    input pipe_pkg::word_t     pc_out,
    input logic                fwd_out_valid,
    input logic                br_taken,
    input logic                flush_if,
    input logic                flush_id,
    input logic                wb_cyc,
    input logic                wb_stb,
    input logic                wb_ack
);

    // a bus cycle opens only right after an accept
    stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc || wb_stb) |->
            wb_cyc && wb_stb && ($past(wb_cyc) || $past(ds_valid && es_allowin)))
        else $error("wishbone stb and cyc out of step");

    cyc_until_ack: assert property (@(posedge clk) disable iff (reset)
        wb_cyc && !wb_ack |=> wb_cyc)
        else $error("wishbone cyc dropped before ack");

    // output held while writeback stalls
    stall_stable: assert property (@(posedge clk) disable iff (reset)
        es_valid_out && !ws_allowin |=>
            es_valid_out && $stable(rd_we) && $stable(rd) && $stable(result) && $stable(pc_out))
        else $error("result changed while writeback was stalled");

    // flushes track br_taken in the first cycle only
    flush_match: assert property (@(posedge clk) disable iff (reset)
        (br_taken || flush_if || flush_id) |->
            br_taken && flush_if && flush_id && es_valid_out && $past(ds_valid && es_allowin))
        else $error("flush or br_taken outside the first cycle of a branch");

    quiet_after_reset: assert property (@(posedge clk) $fell(reset) |->
        es_allowin && !es_valid_out && !wb_cyc && !wb_stb && !br_taken
            && !flush_if && !flush_id && !fwd_out_valid)
        else $error("outputs active right after reset");

endmodule

bind exm_stage exm_sva i_exm_sva (
    .clk           (clk),
    .reset         (reset),
    .ds_valid      (ds_valid),
    .es_allowin    (es_allowin),
    .es_valid_out  (es_valid_out),
    .ws_allowin    (ws_allowin),
    .rd_we         (rd_we),
    .rd            (rd),
    .result        (result),
    .pc_out        (pc_out),
    .fwd_out_valid (fwd_out_valid),
    .br_taken      (br_taken),
    .flush_if      (flush_if),
    .flush_id      (flush_id),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack)
);

// ==== tb_exm_top.sv ====
`timescale 1ns/1ns

module tb_exm_top;

    logic                clk = 1'b0;
    logic                reset;
    logic                ds_valid;
    logic                es_allowin;
    pipe_pkg::word_t     pc;
    pipe_pkg::alu_op_t   alu_op;
    pipe_pkg::br_kind_t  br_kind;
    logic                is_unsigned;
    pipe_pkg::reg_addr_t rj, rk;
    pipe_pkg::word_t     rj_value, rk_value, imm;
    logic                src1_is_pc, src2_is_imm, src2_is_4;
    logic                rd_we_in;
    pipe_pkg::reg_addr_t rd_in;
    logic                mem_rd, mem_wr;
    logic                fwd1_valid, fwd2_valid;
    pipe_pkg::reg_addr_t fwd1_rd, fwd2_rd;
    pipe_pkg::word_t     fwd1_value, fwd2_value;
    logic                ws_allowin;
    logic                es_valid_out;
    logic                rd_we;
    pipe_pkg::reg_addr_t rd;
    pipe_pkg::word_t     result, pc_out;
    logic                fwd_out_valid;
    pipe_pkg::reg_addr_t fwd_out_rd;
    pipe_pkg::word_t     fwd_out_value;
    logic                br_taken;
    pipe_pkg::word_t     br_target;
    logic                flush_if, flush_id;

    logic [31:0]     op_lfsr, ws_lfsr, ws_bits;
    logic            random_ws = 1'b0;
    logic [69:0]     exp_q [$]; // {rd_we, rd, pc, result}
    logic            cur_we, cur_taken, acc_prev, acc_taken;
    pipe_pkg::word_t cur_res, cur_target, acc_target, next_pc;
    pipe_pkg::word_t mem_model [256];
    pipe_pkg::word_t store_addr [8];
    int mon_checks = 0;
    int mon_errors = 0;
    int tb_checks = 0;
    int tb_errors = 0;
    int flush_count = 0;
    int consumed = 0;
    int issued = 0;
    int exp_flush = 0;
    int chk0, err0, cons0, iss0, flush0, exp_flush0;

    exm_top i_exm_top (.*);

    always #20 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(inout logic [31:0] s, input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = s[31] ^ s[21] ^ s[1] ^ s[0];
            s  = {s[30:0], fb};
            v  = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic pipe_pkg::word_t alu_model(input pipe_pkg::alu_op_t op,
                                                  input pipe_pkg::word_t a, b);
        case (op)
            pipe_pkg::ALU_ADD:  return a + b;
            pipe_pkg::ALU_SUB:  return a - b;
            pipe_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            pipe_pkg::ALU_SLTU: return {31'b0, a < b};
            pipe_pkg::ALU_AND:  return a & b;
            pipe_pkg::ALU_OR:   return a | b;
            pipe_pkg::ALU_XOR:  return a ^ b;
            pipe_pkg::ALU_SLL:  return a << b[4:0];
            pipe_pkg::ALU_SRL:  return a >> b[4:0];
            pipe_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
            pipe_pkg::ALU_LUI:  return b;
            default:            return '0;
        endcase
    endfunction

    // ws side, random only while enabled
    initial begin
        ws_allowin = 1'b1;
        ws_lfsr = 32'hda58;
        forever begin
            @(posedge clk);
            #1;
            ws_bits = rand_bits(ws_lfsr, 1);
            ws_allowin = !random_ws || ws_bits[0];
        end
    end

    always @(posedge clk) begin
        logic [69:0]     head;
        logic            exp_t;
        pipe_pkg::word_t exp_tg;
        if (reset) begin
            acc_prev = 1'b0;
        end else begin
            exp_t  = acc_prev && acc_taken;
            exp_tg = exp_t ? acc_target : '0;
            mon_checks++;
            assert (br_taken === exp_t && br_target === exp_tg) else begin
                mon_errors++;
                $display("FAILED at %0t: br_taken %b target %h, expected %b %h",
                         $time, br_taken, br_target, exp_t, exp_tg);
            end
            if (flush_if) flush_count++;
            if (es_valid_out && ws_allowin) consumed++;
            if (es_valid_out) begin
                mon_checks++;
                assert (exp_q.size() != 0) else begin
                    mon_errors++;
                    $display("a result was shown with no instruction outstanding");
                end
            end
            if (es_valid_out && exp_q.size() != 0) begin
                head = exp_q[0];
                mon_checks++;
                assert ({rd_we, rd, pc_out, result} === head) else begin
                    mon_errors++;
                    $display("FAILED at %0t: pc %h rd_we %b rd %0d result %h, expected %h %b %0d %h",
                             $time, pc_out, rd_we, rd, result,
                             head[63:32], head[69], head[68:64], head[31:0]);
                end
                mon_checks++;
                assert (fwd_out_valid === head[69] && (!head[69] ||
                        {fwd_out_rd, fwd_out_value} === {head[68:64], head[31:0]})) else begin
                    mon_errors++;
                    $display("FAILED at %0t: forward %b r%0d %h, expected %b r%0d %h",
                             $time, fwd_out_valid, fwd_out_rd, fwd_out_value,
                             head[69], head[68:64], head[31:0]);
                end
                if (ws_allowin) begin
                    head = exp_q.pop_front();
                end
            end else begin
                mon_checks++;
                assert (fwd_out_valid === 1'b0) else begin
                    mon_errors++;
                    $display("FAILED at %0t: forward valid with no result shown", $time);
                end
            end
            if (ds_valid && es_allowin) begin
                exp_q.push_back({cur_we, rd_in, pc, cur_res});
                acc_taken  = cur_taken;
                acc_target = cur_target;
            end
            acc_prev = ds_valid && es_allowin;
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic expect_count(input string what, input int got, input int want);
        tb_checks++;
        assert (got == want) else begin
            tb_errors++;
            $display("FAILED at %0t: %s %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic clear_fields;
        pc = next_pc;
        next_pc = next_pc + 32'd4;
        alu_op = pipe_pkg::ALU_ADD;
        br_kind = pipe_pkg::BR_NONE;
        is_unsigned = 1'b0;
        rj = 5'd1;
        rk = 5'd2;
        rj_value = '0;
        rk_value = '0;
        imm = '0;
        src1_is_pc = 1'b0;
        src2_is_imm = 1'b0;
        src2_is_4 = 1'b0;
        rd_we_in = 1'b1;
        rd_in = pc[6:2]; // walks through the register numbers
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        cur_we = 1'b1;
        cur_taken = 1'b0;
        cur_target = '0;
    endtask

    task automatic issue;
        int waited;
        ds_valid = 1'b1;
        issued++;
        waited = 0;
        @(posedge clk);
        while (!es_allowin) begin
            if (waited == 100) abort_on_timeout("instruction was not accepted");
            waited++;
            @(posedge clk);
        end
        #2;
        ds_valid = 1'b0;
        fwd1_valid = 1'b0;
        fwd2_valid = 1'b0;
    endtask

    task automatic alu_case(input pipe_pkg::alu_op_t op, input pipe_pkg::word_t a, b);
        clear_fields();
        alu_op = op;
        rj_value = a;
        if (op == pipe_pkg::ALU_LUI) begin
            src2_is_imm = 1'b1;
            imm = b;
        end else begin
            rk_value = b;
        end
        cur_res = alu_model(op, a, b);
        issue();
    endtask

    // src_j and src_k name the winning source: 0 register, 1 port 1, 2 port 2
    task automatic fwd_case(input pipe_pkg::reg_addr_t rjn, rkn, r1, r2, input logic v1, v2,
                            input int src_j, src_k);
        pipe_pkg::word_t a, b, f1, f2, ea, eb;
        clear_fields();
        a  = rand_bits(op_lfsr, 32);
        b  = rand_bits(op_lfsr, 32);
        f1 = rand_bits(op_lfsr, 32);
        f2 = rand_bits(op_lfsr, 32);
        rj = rjn;
        rk = rkn;
        rj_value = a;
        rk_value = b;
        fwd1_valid = v1;
        fwd1_rd = r1;
        fwd1_value = f1;
        fwd2_valid = v2;
        fwd2_rd = r2;
        fwd2_value = f2;
        ea = (src_j == 1) ? f1 : (src_j == 2) ? f2 : a;
        eb = (src_k == 1) ? f1 : (src_k == 2) ? f2 : b;
        cur_res = ea + eb;
        issue();
    endtask

    task automatic branch_case(input pipe_pkg::br_kind_t kind);
        pipe_pkg::word_t a, b, im;
        logic [31:0]     t;
        logic            lt;
        clear_fields();
        a  = rand_bits(op_lfsr, 32);
        t  = rand_bits(op_lfsr, 2);
        b  = t[0] ? a : rand_bits(op_lfsr, 32); // equal operands half the time
        im = rand_bits(op_lfsr, 32);
        lt = t[1] ? a < b : $signed(a) < $signed(b);
        br_kind = kind;
        is_unsigned = t[1];
        rj_value = a;
        rk_value = b;
        imm = im;
        case (kind)
            pipe_pkg::BR_BEQ:  cur_taken = a == b;
            pipe_pkg::BR_BNE:  cur_taken = a != b;
            pipe_pkg::BR_BLT:  cur_taken = lt;
            pipe_pkg::BR_BGE:  cur_taken = !lt;
            pipe_pkg::BR_B:    cur_taken = 1'b1;
            pipe_pkg::BR_JIRL: cur_taken = 1'b1;
            default:           cur_taken = 1'b0;
        endcase
        if (kind == pipe_pkg::BR_B || kind == pipe_pkg::BR_JIRL) begin
            src1_is_pc = 1'b1; // link value pc + 4
            src2_is_4 = 1'b1;
            cur_res = pc + 32'd4;
        end else begin
            alu_op = pipe_pkg::ALU_SUB;
            rd_we_in = 1'b0;
            cur_we = 1'b0;
            cur_res = a - b;
        end
        if (cur_taken) begin
            cur_target = (kind == pipe_pkg::BR_JIRL) ? a + im : pc + im;
            exp_flush++;
        end
        issue();
    endtask

    task automatic store_word(input pipe_pkg::word_t addr, data);
        pipe_pkg::word_t off;
        clear_fields();
        off = rand_bits(op_lfsr, 8);
        mem_wr = 1'b1;
        src2_is_imm = 1'b1;
        rj_value = addr - off;
        imm = off;
        rk_value = data;
        cur_we = 1'b0;
        cur_res = addr;
        mem_model[addr[9:2]] = data;
        issue();
    endtask

    task automatic load_word(input pipe_pkg::word_t addr);
        pipe_pkg::word_t off;
        clear_fields();
        off = rand_bits(op_lfsr, 8);
        mem_rd = 1'b1;
        src2_is_imm = 1'b1;
        rj_value = addr - off;
        imm = off;
        cur_res = mem_model[addr[9:2]];
        issue();
    endtask

    task automatic start_test;
        chk0 = mon_checks + tb_checks;
        err0 = mon_errors + tb_errors;
        cons0 = consumed;
        iss0 = issued;
        flush0 = flush_count;
        exp_flush0 = exp_flush;
    endtask

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == 100) abort_on_timeout("results did not drain");
            waited++;
            @(posedge clk);
            #2;
        end
        expect_count("consumed results", consumed - cons0, issued - iss0);
        expect_count("flush pulses", flush_count - flush0, exp_flush - exp_flush0);
        $display("test %s: %0d checks, %0d errors", name,
                 mon_checks + tb_checks - chk0, mon_errors + tb_errors - err0);
    endtask

    initial begin
        logic [31:0] a, b, t;
        op_lfsr = 32'hda58;
        next_pc = 32'h1c00_0000;
        reset = 1'b1;
        ds_valid = 1'b0;
        fwd1_valid = 1'b0;
        fwd1_rd = '0;
        fwd1_value = '0;
        fwd2_valid = 1'b0;
        fwd2_rd = '0;
        fwd2_value = '0;
        clear_fields();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        start_test();
        for (int k = 0; k < 11; k++) begin
            repeat (4) begin
                a = rand_bits(op_lfsr, 32);
                b = rand_bits(op_lfsr, 32);
                alu_case(pipe_pkg::alu_op_t'(k), a, b);
            end
        end
        end_test("alu");

        start_test();
        repeat (2) begin
            fwd_case(5'd3, 5'd4, 5'd3, 5'd9, 1'b1, 1'b0, 1, 0);
            fwd_case(5'd3, 5'd4, 5'd9, 5'd4, 1'b0, 1'b1, 0, 2);
            fwd_case(5'd3, 5'd4, 5'd3, 5'd3, 1'b1, 1'b1, 1, 0); // port 1 wins
            fwd_case(5'd3, 5'd4, 5'd3, 5'd4, 1'b1, 1'b1, 1, 2);
            fwd_case(5'd0, 5'd4, 5'd0, 5'd0, 1'b1, 1'b1, 0, 0); // r0 stays
            fwd_case(5'd3, 5'd4, 5'd3, 5'd4, 1'b0, 1'b0, 0, 0);
        end
        end_test("forwarding");

        start_test();
        for (int k = 0; k < 7; k++) begin
            repeat (6) branch_case(pipe_pkg::br_kind_t'(k));
        end
        end_test("branch");

        start_test();
        random_ws = 1'b1;
        for (int i = 0; i < 8; i++) begin
            store_addr[i] = rand_bits(op_lfsr, 32);
            store_word(store_addr[i], rand_bits(op_lfsr, 32));
        end
        for (int i = 0; i < 8; i++) begin
            load_word(store_addr[i]);
        end
        end_test("memory");

        start_test();
        repeat (24) begin
            t = rand_bits(op_lfsr, 5);
            a = rand_bits(op_lfsr, 32);
            b = rand_bits(op_lfsr, 32);
            if (t[4:3] == 2'd2) begin
                load_word(store_addr[t[2:0]]);
            end else if (t[4:3] == 2'd3) begin
                store_word(store_addr[t[2:0]], a);
            end else begin
                alu_case(pipe_pkg::alu_op_t'(b % 11), a, b);
            end
        end
        end_test("back-pressure");
        random_ws = 1'b0;

        $display("total: %0d checks, %0d errors", mon_checks + tb_checks, mon_errors + tb_errors);
        if (mon_errors + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
pipe_pkg.sv
alu.sv
branch_unit.sv
data_ram.sv
exm_stage.sv
exm_top.sv
exm_sva.sv
tb_exm_top.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_exm_top -f filelist.f &&
./obj_dir/Vtb_exm_top | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
